// ==== dram_consts.svh ====
/*
  address field positions and DRAM timing counts, all in controller cycles
  the bank, row and column fields must not overlap and must fit DRAM_ADDR_W
  every gap count must fit DRAM_TMR_W bits, and so must DRAM_T_REFI
*/
`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// ******************************
// address layout
// ******************************
`define DRAM_ADDR_W     31      // flat byte address width
`define DRAM_BANK_BITS  2       // four banks
`define DRAM_ROW_BITS   15
`define DRAM_COL_BITS   10
`define DRAM_BANK_LSB   14      // bank in addr[15:14]
`define DRAM_ROW_LSB    16      // row in addr[30:16]
`define DRAM_COL_LSB    4       // col in addr[13:4], addr[3:0] dropped

// ******************************
// timing, in cycles
// ******************************
`define DRAM_T_INIT     20      // power-up wait before the first command
`define DRAM_T_RCD      3       // act to rd/wr
`define DRAM_T_RP       3       // pre/prea to next act or ref
`define DRAM_T_CL       4       // rd to completion
`define DRAM_T_WR       5       // wr to completion
`define DRAM_T_RFC      8       // ref to next command
`define DRAM_T_REFI     200     // refresh interval
`define DRAM_TMR_W      8       // width of both timer counters

`endif

// ==== dram_pkg.sv ====
/*
  field types and encodings shared by the controller blocks
  widths follow dram_consts.svh
  the command encoding is internal, there is no PHY mapping behind it
*/
`default_nettype none

`include "dram_consts.svh"

package dram_pkg;

    // address and its fields
    typedef logic [`DRAM_ADDR_W-1:0]    addr_t;
    typedef logic [`DRAM_BANK_BITS-1:0] bank_t;
    typedef logic [`DRAM_ROW_BITS-1:0]  row_t;
    typedef logic [`DRAM_COL_BITS-1:0]  col_t;

    // row table verdict for the request in idle
    typedef enum logic [1:0] {
        stat_none     = 2'b00,    // no request presented
        stat_hit      = 2'b01,    // bank open on the same row
        stat_miss     = 2'b10,    // bank closed
        stat_conflict = 2'b11     // bank open on another row
    } row_stat_t;

    // command bus encoding, nop when nothing issued
    typedef enum logic [2:0] {
        cmd_nop, cmd_act, cmd_rd, cmd_wr, cmd_pre, cmd_prea, cmd_ref
    } dram_cmd_t;

    // command fsm states, one-cycle command states each followed by a wait state
    typedef enum logic [3:0] {
        power_up,
        idle,
        activate,
        activating,
        read,
        reading,
        write,
        writing,
        precharge,
        precharging,
        prech_all,
        prech_all_wait,
        refresh,
        refreshing
    } cmd_state_t;

endpackage

`default_nettype wire

// ==== dram_addr_mapper.sv ====
/*
  splits the flat request address into bank, row and column
  req_bank/req_row follow addr directly, for the row lookup in idle
  cmd_* hold the fields captured on accept until the next accept,
  so addr may change as soon as req_done is seen
*/
`default_nettype none

`include "dram_consts.svh"

module dram_addr_mapper import dram_pkg::*; (
    input  logic  tb_CLK,
    input  logic  reset,
    input  addr_t addr,       // requester address, held with the request level
    input  logic  accept,     // fsm takes the request this cycle
    output bank_t req_bank,   // live fields for the row table
    output row_t  req_row,
    output bank_t cmd_bank,   // captured fields for the command bus
    output row_t  cmd_row,
    output col_t  cmd_col
);

    col_t req_col;    // live column, only ever registered

    // field extraction, pure slicing
    assign req_bank = addr[`DRAM_BANK_LSB +: `DRAM_BANK_BITS];
    assign req_row  = addr[`DRAM_ROW_LSB  +: `DRAM_ROW_BITS];
    assign req_col  = addr[`DRAM_COL_LSB  +: `DRAM_COL_BITS];   // low nibble ignored

    // ******************************
    // capture on accept
    // ******************************
    always_ff @(posedge tb_CLK) begin
        if (reset) begin
            cmd_bank <= '0;
            cmd_row  <= '0;
            cmd_col  <= '0;
        end else if (accept) begin
            cmd_bank <= req_bank;   // stays put for act/pre/rd/wr of this request
            cmd_row  <= req_row;
            cmd_col  <= req_col;
        end
    end

endmodule

`default_nettype wire

// ==== dram_row_table.sv ====
/*
  open-row table, one valid bit and one row per bank
  all banks closed after reset
  row_stat is combinational from req_en/req_bank/req_row and is only
  meaningful while the fsm sits in idle
  updates use the captured cmd_bank/cmd_row, never the live fields
*/
`default_nettype none

`include "dram_consts.svh"

module dram_row_table import dram_pkg::*; (
    input  logic      tb_CLK,
    input  logic      reset,
    input  logic      req_en,      // request being taken, qualifies row_stat
    input  bank_t     req_bank,
    input  row_t      req_row,
    input  logic      act_fire,    // act issued, open cmd_row in cmd_bank
    input  logic      pre_fire,    // pre issued, close cmd_bank
    input  logic      prea_fire,   // prea issued, close everything
    input  bank_t     cmd_bank,
    input  row_t      cmd_row,
    output row_stat_t row_stat,
    output logic      any_open     // at least one bank holds an open row
);

    localparam int n_banks = 1 << `DRAM_BANK_BITS;

    logic [n_banks-1:0] bank_valid;          // bank has an open row
    row_t               open_row [n_banks];  // which row, valid only with bank_valid

    // ******************************
    // state update
    // ******************************
    always_ff @(posedge tb_CLK) begin
        if (reset) begin
            bank_valid <= '0;
        end else if (prea_fire) begin
            bank_valid <= '0;                  // all banks precharged
        end else if (pre_fire) begin
            bank_valid[cmd_bank] <= 1'b0;
        end else if (act_fire) begin
            bank_valid[cmd_bank] <= 1'b1;
        end
    end

    // row storage, only read under bank_valid
    always_ff @(posedge tb_CLK) begin
        if (act_fire) begin
            open_row[cmd_bank] <= cmd_row;
        end
    end

    // ******************************
    // classification
    // ******************************
    always_comb begin
        if (!req_en) begin
            row_stat = stat_none;
        end else if (!bank_valid[req_bank]) begin
            row_stat = stat_miss;              // closed bank, needs act
        end else if (open_row[req_bank] == req_row) begin
            row_stat = stat_hit;               // go straight to rd/wr
        end else begin
            row_stat = stat_conflict;          // pre then act
        end
    end

    assign any_open = |bank_valid;   // decides whether refresh needs prea first

endmodule

`default_nettype wire

// ==== dram_timer.sv ====
/*
  one down-counter for all command gaps plus a free-running refresh pacer
  done is high for exactly one cycle, load_count cycles after start
  load_count of zero never raises done, the fsm never loads it
  after reset the gap counter runs the power-up wait by itself
  the refresh pacer stays cleared until that wait ends
*/
`default_nettype none

`include "dram_consts.svh"

module dram_timer (
    input  logic                   tb_CLK,
    input  logic                   reset,
    input  logic                   start,        // fsm issues a command this cycle
    input  logic [`DRAM_TMR_W-1:0] load_count,   // gap to wait for that command
    input  logic                   rf_ack,       // fsm issued ref
    output logic                   done,         // gap elapsed, wait state may leave
    output logic                   rf_req        // refresh due, held until rf_ack
);

    localparam logic [`DRAM_TMR_W-1:0] init_count = `DRAM_T_INIT;
    localparam logic [`DRAM_TMR_W-1:0] refi_last  = `DRAM_T_REFI - 1;
    localparam logic [`DRAM_TMR_W-1:0] cnt_one    = 1;

    logic [`DRAM_TMR_W-1:0] gap_cnt;    // cycles left in the current gap
    logic [`DRAM_TMR_W-1:0] refi_cnt;   // cycles since the last refresh tick
    logic                   init_busy;  // power-up wait still running

    assign done = (gap_cnt == cnt_one);   // last cycle of the gap

    // ******************************
    // gap counter
    // ******************************
    always_ff @(posedge tb_CLK) begin
        if (reset) begin
            gap_cnt   <= init_count;   // self start for power-up
            init_busy <= 1'b1;
        end else begin
            if (start) begin
                gap_cnt <= load_count;
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;   // parks at zero
            end
            if (done) begin
                init_busy <= 1'b0;           // first done ends power-up
            end
        end
    end

    // ******************************
    // refresh pacer
    // ******************************
    always_ff @(posedge tb_CLK) begin
        if (reset || init_busy) begin
            refi_cnt <= '0;
            rf_req   <= 1'b0;
        end else if (refi_cnt == refi_last) begin
            refi_cnt <= '0;
            rf_req   <= 1'b1;                // a new tick wins over a late ack
        end else begin
            refi_cnt <= refi_cnt + 1'b1;
            if (rf_ack) begin
                rf_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dram_cmd_fsm.sv ====
/*
  command fsm, includes the power-up wait as its first state
  one command per command state, each followed by a wait on the timer
  refresh beats a pending request in idle; requests are ignored while
  req_done is high, so the requester has one cycle to drop its level
  only one gap is timed at a time, no overlap across banks
*/
`default_nettype none

`include "dram_consts.svh"

module dram_cmd_fsm import dram_pkg::*; (
    input  logic                   tb_CLK,
    input  logic                   reset,
    input  logic                   rd_req,       // level, held until req_done
    input  logic                   wr_req,       // level, never with rd_req
    input  row_stat_t              row_stat,
    input  logic                   any_open,
    input  logic                   done,         // timer gap elapsed
    input  logic                   rf_req,
    output logic                   accept,       // request taken, also row lookup enable
    output logic                   act_fire,
    output logic                   pre_fire,
    output logic                   prea_fire,
    output logic                   start,        // load the timer this cycle
    output logic [`DRAM_TMR_W-1:0] load_count,
    output logic                   rf_ack,
    output dram_cmd_t              cmd,
    output cmd_state_t             cmd_state,
    output logic                   init_done,
    output logic                   req_done
);

    localparam logic [`DRAM_TMR_W-1:0] ld_rcd = `DRAM_T_RCD;
    localparam logic [`DRAM_TMR_W-1:0] ld_rp  = `DRAM_T_RP;
    localparam logic [`DRAM_TMR_W-1:0] ld_cl  = `DRAM_T_CL;
    localparam logic [`DRAM_TMR_W-1:0] ld_wr  = `DRAM_T_WR;
    localparam logic [`DRAM_TMR_W-1:0] ld_rfc = `DRAM_T_RFC;

    cmd_state_t state, state_nxt;
    logic       is_write;   // direction of the accepted request

    assign cmd_state = state;
    assign accept    = (state == idle) && (rd_req || wr_req) && !rf_req && !req_done;

    // ******************************
    // next state
    // ******************************
    always_comb begin
        state_nxt = state;
        case (state)
            power_up:       if (done) state_nxt = idle;
            idle: begin
                if (rf_req) begin
                    state_nxt = any_open ? prech_all : refresh;   // close rows first
                end else if (accept) begin
                    case (row_stat)
                        stat_hit:      state_nxt = wr_req ? write : read;
                        stat_miss:     state_nxt = activate;
                        stat_conflict: state_nxt = precharge;
                        default:       state_nxt = idle;
                    endcase
                end
            end
            activate:       state_nxt = activating;
            activating:     if (done) state_nxt = is_write ? write : read;
            read:           state_nxt = reading;
            reading:        if (done) state_nxt = idle;
            write:          state_nxt = writing;
            writing:        if (done) state_nxt = idle;
            precharge:      state_nxt = precharging;
            precharging:    if (done) state_nxt = activate;   // conflict path goes on to act
            prech_all:      state_nxt = prech_all_wait;
            prech_all_wait: if (done) state_nxt = refresh;
            refresh:        state_nxt = refreshing;
            refreshing:     if (done) state_nxt = idle;
            default:        state_nxt = idle;
        endcase
    end

    // ******************************
    // state and status registers
    // ******************************
    always_ff @(posedge tb_CLK) begin
        if (reset) begin
            state     <= power_up;
            is_write  <= 1'b0;
            init_done <= 1'b0;
            req_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                is_write <= wr_req;
            end
            if (state == power_up && done) begin
                init_done <= 1'b1;    // sticky from the first idle cycle
            end
            req_done <= (state == reading || state == writing) && done;   // lands in idle
        end
    end

    // ******************************
    // command and timer load
    // ******************************
    always_comb begin
        cmd        = cmd_nop;
        start      = 1'b0;
        load_count = '0;
        case (state)
            activate: begin
                cmd        = cmd_act;
                start      = 1'b1;
                load_count = ld_rcd;
            end
            read: begin
                cmd        = cmd_rd;
                start      = 1'b1;
                load_count = ld_cl;
            end
            write: begin
                cmd        = cmd_wr;
                start      = 1'b1;
                load_count = ld_wr;
            end
            precharge, prech_all: begin
                cmd        = (state == precharge) ? cmd_pre : cmd_prea;
                start      = 1'b1;
                load_count = ld_rp;
            end
            refresh: begin
                cmd        = cmd_ref;
                start      = 1'b1;
                load_count = ld_rfc;
            end
            default: ;   // wait states and idle issue nothing
        endcase
    end

    // row table updates ride on the command cycle
    assign act_fire  = (state == activate);
    assign pre_fire  = (state == precharge);
    assign prea_fire = (state == prech_all);
    assign rf_ack    = (state == refresh);

endmodule

`default_nettype wire

// ==== dram_ctrl_top.sv ====
/*
  controller slice top, wiring only
  one clock, synchronous active-high reset
  requests are levels held until req_done, there is no other back-pressure
  cmd_bank/cmd_row/cmd_col are valid whenever cmd is not nop
*/
`default_nettype none

`include "dram_consts.svh"

module dram_ctrl_top import dram_pkg::*; (
    input  logic       tb_CLK,
    input  logic       reset,
    input  logic       rd_req,
    input  logic       wr_req,
    input  addr_t      addr,
    output dram_cmd_t  cmd,
    output bank_t      cmd_bank,
    output row_t       cmd_row,
    output col_t       cmd_col,
    output cmd_state_t cmd_state,
    output logic       init_done,
    output logic       req_done
);

    // ******************************
    // internal nets
    // ******************************
    bank_t                  req_bank;      // live fields to the row table
    row_t                   req_row;
    logic                   accept;        // also the row lookup enable
    logic                   act_fire, pre_fire, prea_fire;
    row_stat_t              row_stat;
    logic                   any_open;
    logic                   start, done;
    logic [`DRAM_TMR_W-1:0] load_count;
    logic                   rf_req, rf_ack;

    dram_addr_mapper u_mapper (
        .tb_CLK, .reset, .addr, .accept,
        .req_bank, .req_row, .cmd_bank, .cmd_row, .cmd_col
    );

    dram_row_table u_rows (
        .tb_CLK, .reset, .req_en(accept), .req_bank, .req_row,
        .act_fire, .pre_fire, .prea_fire, .cmd_bank, .cmd_row,
        .row_stat, .any_open
    );

    dram_timer u_timer (
        .tb_CLK, .reset, .start, .load_count, .rf_ack, .done, .rf_req
    );

    dram_cmd_fsm u_fsm (
        .tb_CLK, .reset, .rd_req, .wr_req, .row_stat, .any_open, .done, .rf_req,
        .accept, .act_fire, .pre_fire, .prea_fire, .start, .load_count, .rf_ack,
        .cmd, .cmd_state, .init_done, .req_done
    );

endmodule

`default_nettype wire

// ==== dram_ctrl_tb.sv ====
/*
  self-checking testbench for dram_ctrl_top
  an open-row model predicts each request's commands, the monitor checks
  every non-nop command and the minimum gaps between commands
  refresh ticks are predicted from the cycle count and a request is only
  raised while the controller is idle with no refresh due
*/
`default_nettype none

`include "dram_consts.svh"

module dram_ctrl_tb import dram_pkg::*; ();

    localparam int n_banks   = 1 << `DRAM_BANK_BITS;
    localparam int n_random  = 40;
    localparam int n_reqs    = n_random + 5;
    localparam int worst_seq = (`DRAM_T_RP + 1) + (`DRAM_T_RCD + 1) + (`DRAM_T_WR + 1) + 4;
    localparam int ref_allow = `DRAM_T_REFI
        + ((n_reqs * worst_seq) / `DRAM_T_REFI + 2) * (`DRAM_T_RP + `DRAM_T_RFC + 4);
    localparam int max_cycles = 2 * (16 + `DRAM_T_INIT + n_reqs * worst_seq + ref_allow);

    logic       tb_CLK;
    logic       reset;
    logic       rd_req;
    logic       wr_req;
    addr_t      addr;
    dram_cmd_t  cmd;
    bank_t      cmd_bank;
    row_t       cmd_row;
    col_t       cmd_col;
    cmd_state_t cmd_state;
    logic       init_done;
    logic       req_done;

    // open-row model and the expected command stream
    logic      model_valid [n_banks];
    row_t      model_row   [n_banks];
    dram_cmd_t exp_cmd  [$];
    bank_t     exp_bank [$];
    row_t      exp_row  [$];
    col_t      exp_col  [$];
    row_t      row_pool [3] = '{15'h0123, 15'h0456, 15'h7ffe};   // small pool gives many conflicts

    int        cyc;            // rising edges since reset release
    int        run_cyc;        // all rising edges for the timeout
    int        ref_count;      // ref commands seen
    int        outstanding;    // request raised and req_done not yet seen
    int        last_cyc;
    int        prea_cyc;
    int        ref_cyc;
    dram_cmd_t last_cmd;
    logic      prea_pending;   // prea seen and ref must come next
    logic      after_ref;

    dram_ctrl_top u_dut (
        .tb_CLK, .reset, .rd_req, .wr_req, .addr,
        .cmd, .cmd_bank, .cmd_row, .cmd_col, .cmd_state, .init_done, .req_done
    );

    always #2 tb_CLK = ~tb_CLK;   // period 4

    // ******************************
    // failure and compare tasks
    // ******************************
    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_cmd(input string name, input dram_cmd_t got, input dram_cmd_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_col(input string name, input col_t got, input col_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_state(input string name, input cmd_state_t got, input cmd_state_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // gaps are minimums and never exact
    task automatic check_gap(input string name, input int got, input int min);
        if (got < min)
            fail_run($sformatf("mismatch at %0t: %s gap got %0d expected at least %0d",
                               $time, name, got, min));
    endtask

    // ******************************
    // reference model
    // ******************************
    function automatic void push_cmd(input dram_cmd_t c, input bank_t b, input row_t r,
                                     input col_t cl);
        exp_cmd.push_back(c);
        exp_bank.push_back(b);
        exp_row.push_back(r);
        exp_col.push_back(cl);
    endfunction

    // expected commands for one request with the model updated as the DRAM would be
    function automatic void expect_cmds(input addr_t a, input logic is_wr);
        bank_t b;
        row_t  r;
        col_t  c;
        b = a[`DRAM_BANK_LSB +: `DRAM_BANK_BITS];
        r = a[`DRAM_ROW_LSB +: `DRAM_ROW_BITS];
        c = a[`DRAM_COL_LSB +: `DRAM_COL_BITS];
        if (model_valid[b] && model_row[b] != r) begin
            push_cmd(cmd_pre, b, r, c);        // conflict closes the bank first
            model_valid[b] = 1'b0;
        end
        if (!model_valid[b]) begin
            push_cmd(cmd_act, b, r, c);
            model_valid[b] = 1'b1;
            model_row[b]   = r;
        end
        push_cmd(is_wr ? cmd_wr : cmd_rd, b, r, c);
    endfunction

    function automatic logic model_any_open();
        logic any;
        any = 1'b0;
        for (int i = 0; i < n_banks; i++) any |= model_valid[i];
        return any;
    endfunction

    // pacer starts once the power-up wait ends so the first tick is at T_INIT + T_REFI edges
    function automatic int refresh_ticks(input int c);
        if (c < `DRAM_T_INIT + `DRAM_T_REFI) return 0;
        return (c - `DRAM_T_INIT - `DRAM_T_REFI) / `DRAM_T_REFI + 1;
    endfunction

    function automatic addr_t make_addr(input bank_t b, input row_t r, input col_t c,
                                        input logic [`DRAM_COL_LSB-1:0] low);
        addr_t a;
        a = '0;
        a[`DRAM_BANK_LSB +: `DRAM_BANK_BITS] = b;
        a[`DRAM_ROW_LSB +: `DRAM_ROW_BITS]   = r;
        a[`DRAM_COL_LSB +: `DRAM_COL_BITS]   = c;
        a[`DRAM_COL_LSB-1:0]                 = low;   // ignored by the dut
        return a;
    endfunction

    // ******************************
    // monitor
    // ******************************
    task automatic handle_cmd();
        case (cmd)
            cmd_prea: begin
                if (!model_any_open()) fail_run("prea issued while no row was open");
                if (exp_cmd.size() != 0) fail_run("prea issued inside a request sequence");
                prea_pending = 1'b1;
                prea_cyc     = cyc;
            end
            cmd_ref: begin
                if (exp_cmd.size() != 0) fail_run("ref issued inside a request sequence");
                if (model_any_open()) begin
                    if (!prea_pending) fail_run("ref issued with rows open and no prea");
                    check_gap("prea to ref", cyc - prea_cyc, `DRAM_T_RP + 1);
                end
                for (int i = 0; i < n_banks; i++) model_valid[i] = 1'b0;   // all closed
                prea_pending = 1'b0;
                after_ref    = 1'b1;
                ref_cyc      = cyc;
                ref_count++;
            end
            default: begin
                if (prea_pending) fail_run("request command between prea and ref");
                if (exp_cmd.size() == 0) fail_run("unexpected command, no request outstanding");
                check_cmd("cmd", cmd, exp_cmd.pop_front());
                check_bank("cmd_bank", cmd_bank, exp_bank.pop_front());
                check_row("cmd_row", cmd_row, exp_row.pop_front());
                check_col("cmd_col", cmd_col, exp_col.pop_front());
                if (cmd == cmd_act && last_cmd == cmd_pre)
                    check_gap("pre to act", cyc - last_cyc, `DRAM_T_RP + 1);
                if ((cmd == cmd_rd || cmd == cmd_wr) && last_cmd == cmd_act)
                    check_gap("act to rd/wr", cyc - last_cyc, `DRAM_T_RCD + 1);
                if (after_ref) check_gap("ref to next command", cyc - ref_cyc, `DRAM_T_RFC + 1);
                after_ref = 1'b0;
                last_cmd  = cmd;
                last_cyc  = cyc;
            end
        endcase
    endtask

    task automatic handle_done();
        if (outstanding == 0) fail_run("req_done pulsed with no request outstanding");
        if (exp_cmd.size() != 0) fail_run("req_done came before all expected commands");
        if (last_cmd == cmd_rd)
            check_gap("rd to req_done", cyc - last_cyc, `DRAM_T_CL + 1);
        else
            check_gap("wr to req_done", cyc - last_cyc, `DRAM_T_WR + 1);
        outstanding = 0;
    endtask

    always @(posedge tb_CLK) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
    end

    always @(posedge tb_CLK) begin
        if (!reset) begin
            if (cyc >= `DRAM_T_INIT && !init_done) fail_run("init_done low after power-up ended");
            if (cmd != cmd_nop) handle_cmd();
            if (req_done) handle_done();
        end
    end

    always @(posedge tb_CLK) begin
        run_cyc++;
        if (run_cyc > max_cycles) fail_run($sformatf("timeout after %0d cycles", run_cyc));
    end

    // ******************************
    // stimulus
    // ******************************
    // idle with no refresh due so the next edge takes the request
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge tb_CLK);   // step past the req_done cycle
        while (cmd_state != idle || refresh_ticks(cyc) > ref_count) begin
            if (n > 2 * (`DRAM_T_RP + `DRAM_T_RFC) + worst_seq)
                fail_run("controller never settled in idle");
            n++;
            @(negedge tb_CLK);
        end
    endtask

    task automatic do_request(input addr_t a, input logic is_wr);
        int n;
        wait_ready();
        expect_cmds(a, is_wr);
        addr        = a;
        rd_req      = !is_wr;
        wr_req      = is_wr;
        outstanding = 1;
        n = 0;
        @(negedge tb_CLK);
        while (!req_done) begin
            if (n > 3 * worst_seq) fail_run("req_done never came for the pending request");
            n++;
            @(negedge tb_CLK);
        end
        rd_req = 1'b0;       // dropped inside the req_done cycle
        wr_req = 1'b0;
    endtask

    initial begin
        int n;
        int seen;
        void'($urandom(32'hc22c_2fcd));
        tb_CLK = 1'b0;
        reset  = 1'b1;
        rd_req = 1'b0;
        wr_req = 1'b0;
        addr   = '0;
        run_cyc      = 0;
        ref_count    = 0;
        outstanding  = 0;
        last_cyc     = 0;
        last_cmd     = cmd_nop;
        prea_pending = 1'b0;
        after_ref    = 1'b0;
        for (int i = 0; i < n_banks; i++) model_valid[i] = 1'b0;
        repeat (16) @(posedge tb_CLK);
        @(negedge tb_CLK);
        reset = 1'b0;

        // power-up holds cmd at nop for exactly T_INIT cycles
        n = 0;
        do begin
            @(negedge tb_CLK);
            n++;
            check_cmd("cmd during power-up", cmd, cmd_nop);
            if (n > `DRAM_T_INIT + 8) fail_run("init_done never rose after power-up");
        end while (!init_done);
        check_count("power-up cycles", n, `DRAM_T_INIT);
        check_state("cmd_state after power-up", cmd_state, idle);

        do_request(make_addr(2'd1, 15'h0123, 10'h02a, 4'h3), 1'b0);   // miss gives act then rd
        do_request(make_addr(2'd1, 15'h0123, 10'h055, 4'h0), 1'b1);   // hit gives wr only
        do_request(make_addr(2'd1, 15'h0456, 10'h100, 4'hf), 1'b0);   // conflict

        // refresh with bank 1 open and the same row needing act again
        seen = ref_count;
        n = 0;
        while (ref_count == seen) begin
            if (n > `DRAM_T_INIT + 2 * `DRAM_T_REFI) fail_run("refresh never issued");
            n++;
            @(negedge tb_CLK);
        end
        do_request(make_addr(2'd1, 15'h0456, 10'h101, 4'h0), 1'b0);

        for (int k = 0; k < n_random; k++) begin
            do_request(make_addr(bank_t'($urandom_range(n_banks - 1, 0)),
                                 row_pool[$urandom_range(2, 0)],
                                 col_t'($urandom), 4'($urandom)),
                       1'($urandom_range(1, 0)));
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dram_ctrl.f ====
+incdir+.
dram_pkg.sv
dram_addr_mapper.sv
dram_row_table.sv
dram_timer.sv
dram_cmd_fsm.sv
dram_ctrl_top.sv
dram_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: dram_ctrl

sources:
  - include_dirs:
      - .
    files:
      - dram_pkg.sv
      - dram_addr_mapper.sv
      - dram_row_table.sv
      - dram_timer.sv
      - dram_cmd_fsm.sv
      - dram_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dram_ctrl_tb.sv
